//--- src.f
+incdir+rtl
rtl/act_buf_pkg.sv
rtl/sram_macro_model.sv
rtl/act_buf_ram.sv
rtl/pixel_packer.sv
rtl/word_pooler.sv
rtl/act_buf_top.sv
tb/act_buf_props.sv
tb/act_buf_tb.sv

//--- tb/act_buf_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module act_buf_tb;

    localparam int N_ENTRIES = 6;
    localparam int WORD_BITS = `ACT_LANES * `ACT_LANE_BITS;
    localparam int SUM_BITS  = $clog2(`ACT_LANES) + `ACT_LANE_BITS;

    // Frame length in pixels, expected result count, random gaps on or off.
    int frame_len [N_ENTRIES] = '{16, 1, 37, 160, 1024, 33};
    int n_words   [N_ENTRIES] = '{1, 1, 3, 10, 64, 3};
    bit gap_mode  [N_ENTRIES] = '{0, 0, 0, 0, 0, 1};

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   pixel_valid;
    logic                   pixel_last;
    act_buf_pkg::lane_t     pixel;
    logic                   busy;
    logic                   pool_valid;
    logic [SUM_BITS-1:0]    pool_sum;
    act_buf_pkg::lane_t     pool_max;
    logic [WORD_BITS-1:0]   pool_word;
    logic                   done;

    act_buf_pkg::act_word_u exp_q [$];
    act_buf_pkg::lane_t     px_q [$];
    logic                   gap_q [$];
    logic [15:0]            lfsr_state;
    int                     cyc = 0;
    int                     timeout_limit;
    int                     last_cyc;
    int                     seen;
    int                     cur_words;
    int                     frames_done = 0;
    bit                     started = 1'b0;
    bit                     exp_busy = 1'b0; // Busy from first pixel through done.

    act_buf_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .pixel_valid (pixel_valid),
        .pixel_last  (pixel_last),
        .pixel       (pixel),
        .busy        (busy),
        .pool_valid  (pool_valid),
        .pool_sum    (pool_sum),
        .pool_max    (pool_max),
        .pool_word   (pool_word),
        .done        (done)
    );

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [WORD_BITS-1:0] exp,
                                 input logic [WORD_BITS-1:0] act);
        assert (act === exp) else begin
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Failure at %0t: %s", $time, what);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_step_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    task automatic build_frame(input int e);
        act_buf_pkg::act_word_u w;
        act_buf_pkg::lane_t     p;
        w = '0;
        px_q.delete();
        gap_q.delete();
        for (int i = 0; i < frame_len[e]; i++) begin
            p = '0;
            for (int k = 0; k < `ACT_LANE_BITS; k++) begin
                p = {p[`ACT_LANE_BITS-2:0], lfsr_step_bit()};
            end
            px_q.push_back(p);
            if (gap_mode[e]) begin
                gap_q.push_back(lfsr_step_bit());
            end else begin
                gap_q.push_back(1'b0);
            end
            w.lanes[i % `ACT_LANES] = p; // First pixel lands in lane 0.
            if (i % `ACT_LANES == `ACT_LANES - 1 || i == frame_len[e] - 1) begin
                exp_q.push_back(w);
                w = '0; // Padding above the last pixel stays zero.
            end
        end
        compare_value("expected word count", n_words[e], exp_q.size());
        cur_words = n_words[e];
    endtask

    task automatic drive_frame(input int e);
        for (int i = 0; i < frame_len[e]; i++) begin
            @(posedge clk);
            pixel_valid <= 1'b1;
            pixel_last  <= (i == frame_len[e] - 1);
            pixel       <= px_q[i];
            if (gap_q[i]) begin
                @(posedge clk);
                pixel_valid <= 1'b0;
                pixel_last  <= 1'b0;
            end
        end
        @(posedge clk);
        pixel_valid <= 1'b0;
        pixel_last  <= 1'b0;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_limit) begin
            $display("Timeout: the frames did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Outputs are sampled half a cycle after the edge that set them.
    always @(negedge clk) begin : monitor
        act_buf_pkg::act_word_u exp_w;
        logic [SUM_BITS-1:0]    exp_sum;
        act_buf_pkg::lane_t     exp_max;
        if (arst_n) begin
            if (!started) begin
                require(!busy && !pool_valid && !done, "output active before the first pixel");
            end
            compare_value("busy", exp_busy, busy);
            if (pixel_valid) begin
                started  = 1'b1;
                exp_busy = 1'b1;
            end else if (done) begin
                exp_busy = 1'b0;
            end
            if (pixel_valid && pixel_last) begin
                last_cyc = cyc;
                seen     = 0;
            end
            if (pool_valid) begin
                require(exp_q.size() > 0, "pool_valid strobed with no result expected");
                exp_w   = exp_q.pop_front();
                exp_sum = '0;
                exp_max = '0;
                for (int i = 0; i < `ACT_LANES; i++) begin
                    exp_sum = exp_sum + exp_w.lanes[i];
                    if (exp_w.lanes[i] > exp_max) begin
                        exp_max = exp_w.lanes[i];
                    end
                end
                compare_value("pool_valid cycle", last_cyc + 5 + seen, cyc);
                compare_value("pool_word", exp_w.flat, pool_word);
                compare_value("pool_sum", exp_sum, pool_sum);
                compare_value("pool_max", exp_max, pool_max);
                seen = seen + 1;
            end
            if (done) begin
                compare_value("result count", cur_words, seen);
                compare_value("done cycle", last_cyc + 5 + seen, cyc);
                frames_done = frames_done + 1;
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        pixel_valid = 1'b0;
        pixel_last  = 1'b0;
        pixel       = '0;
        lfsr_state  = 16'd50059;
        timeout_limit = 0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            timeout_limit = timeout_limit + 2 * frame_len[e] + 2 * n_words[e] + 20;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk); // Idle cycles to see quiet outputs.
        for (int e = 0; e < N_ENTRIES; e++) begin
            build_frame(e);
            drive_frame(e);
            wait (frames_done == e + 1);
            @(negedge clk);
            while (busy) begin
                @(negedge clk);
            end
        end
        require(exp_q.size() == 0, "expected results left over after the last frame");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/act_buf_props.sv
`timescale 1ns/100ps
`default_nettype none

module act_buf_props (
    input logic clk,
    input logic arst_n,
    input logic pixel_valid,
    input logic pixel_last,
    input logic busy,
    input logic pool_valid,
    input logic done
);

    logic frame_closed; // Last pixel taken, results not yet done.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_closed <= 1'b0;
        end else if (done) begin
            frame_closed <= 1'b0;
        end else if (pixel_valid && pixel_last) begin
            frame_closed <= 1'b1;
        end
    end

    no_pixel_while_draining: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(pixel_valid && busy && frame_closed)
    ) else $error("pixel sent after the last pixel while the frame is still busy");

    result_and_done_apart: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(pool_valid && done)
    ) else $error("pool_valid and done high in the same cycle");

    done_is_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    ) else $error("done held high for more than one cycle");

endmodule

bind act_buf_top act_buf_props u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .pixel_valid (pixel_valid),
    .pixel_last  (pixel_last),
    .busy        (busy),
    .pool_valid  (pool_valid),
    .done        (done)
);

`default_nettype wire

//--- rtl/act_buf_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module act_buf_top (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          pixel_valid,
    input  logic                                          pixel_last,
    input  act_buf_pkg::lane_t                            pixel,
    output logic                                          busy,
    output logic                                          pool_valid,
    output logic [$clog2(`ACT_LANES)+`ACT_LANE_BITS-1:0]  pool_sum,
    output act_buf_pkg::lane_t                            pool_max,
    output logic [`ACT_LANES*`ACT_LANE_BITS-1:0]          pool_word,
    output logic                                          done
);

    logic                                        write_en;
    logic [$clog2(`ACT_SRAM_WORDS)-1:0]          addr_w;
    act_buf_pkg::act_word_u                      data_in;
    logic                                        frame_done;
    logic [$clog2(`ACT_SRAM_WORDS):0]            frame_words;
    logic                                        read_en;
    logic [$clog2(`ACT_SRAM_WORDS)-1:0]          addr_r;
    logic [`ACT_LANES*`ACT_LANE_BITS-1:0]        data_out;
    logic                                        busy_read;
    logic                                        busy_q;

    pixel_packer u_packer (
        .clk         (clk),
        .arst_n      (arst_n),
        .pixel_valid (pixel_valid),
        .pixel_last  (pixel_last),
        .pixel       (pixel),
        .write_en    (write_en),
        .addr_w      (addr_w),
        .data_in     (data_in),
        .frame_done  (frame_done),
        .frame_words (frame_words)
    );

    act_buf_ram #(
        .words    (`ACT_SRAM_WORDS),
        .width    (`ACT_LANES * `ACT_LANE_BITS)
    ) u_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr_r   (addr_r),
        .addr_w   (addr_w),
        .read_en  (read_en),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out)
    );

    word_pooler u_pooler (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_done  (frame_done),
        .frame_words (frame_words),
        .data_out    (data_out),
        .read_en     (read_en),
        .addr_r      (addr_r),
        .pool_valid  (pool_valid),
        .pool_sum    (pool_sum),
        .pool_max    (pool_max),
        .pool_word   (pool_word),
        .done        (done),
        .busy_read   (busy_read)
    );

    // Frame flag, up from the first pixel until the pooler is done.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
        end else if (pixel_valid) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    assign busy = busy_q | busy_read; // Read phase always counts as busy.

endmodule

`default_nettype wire

//--- rtl/word_pooler.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module word_pooler (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          frame_done,
    input  logic [$clog2(`ACT_SRAM_WORDS):0]              frame_words,
    input  act_buf_pkg::act_word_u                        data_out,
    output logic                                          read_en,
    output logic [$clog2(`ACT_SRAM_WORDS)-1:0]            addr_r,
    output logic                                          pool_valid,
    output logic [$clog2(`ACT_LANES)+`ACT_LANE_BITS-1:0]  pool_sum,
    output act_buf_pkg::lane_t                            pool_max,
    output logic [`ACT_LANES*`ACT_LANE_BITS-1:0]          pool_word,
    output logic                                          done,
    output logic                                          busy_read
);

    localparam int SUM_BITS = $clog2(`ACT_LANES) + `ACT_LANE_BITS;

    logic [$clog2(`ACT_SRAM_WORDS):0]  rd_left;
    logic                              data_valid;
    logic [SUM_BITS-1:0]               lane_sum;
    act_buf_pkg::lane_t                lane_max;

    // Read sequencer. One read per cycle from word 0 up.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_en <= 1'b0;
            addr_r  <= '0;
            rd_left <= '0;
        end else if (frame_done) begin
            read_en <= 1'b1;
            addr_r  <= '0;
            rd_left <= frame_words - 1'b1; // Reads left after this one.
        end else if (read_en) begin
            addr_r <= addr_r + 1'b1;
            if (rd_left == '0) begin
                read_en <= 1'b0;
            end else begin
                rd_left <= rd_left - 1'b1;
            end
        end
    end

    // Stage one is the RAM latency, stage two the result register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_valid <= 1'b0;
            pool_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            data_valid <= read_en;
            pool_valid <= data_valid;
            done       <= pool_valid && !data_valid; // Last result just went out.
        end
    end

    // Sum cannot overflow 12 bits for 16 lanes of 8 bits.
    always_comb begin
        lane_sum = '0;
        lane_max = '0;
        for (int i = 0; i < `ACT_LANES; i++) begin
            lane_sum = lane_sum + data_out.lanes[i];
            if (data_out.lanes[i] > lane_max) begin
                lane_max = data_out.lanes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            pool_sum  <= lane_sum;
            pool_max  <= lane_max;
            pool_word <= data_out.flat;
        end
    end

    assign busy_read = read_en | data_valid | pool_valid | done;

endmodule

`default_nettype wire

//--- rtl/pixel_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module pixel_packer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                pixel_valid,
    input  logic                                pixel_last,
    input  act_buf_pkg::lane_t                  pixel,
    output logic                                write_en,
    output logic [$clog2(`ACT_SRAM_WORDS)-1:0]  addr_w,
    output act_buf_pkg::act_word_u              data_in,
    output logic                                frame_done,
    output logic [$clog2(`ACT_SRAM_WORDS):0]    frame_words
);

    localparam int IDX_BITS = $clog2(`ACT_LANES);
    localparam logic [IDX_BITS-1:0] LAST_LANE = IDX_BITS'(`ACT_LANES - 1);

    logic [IDX_BITS-1:0]     lane_idx;
    logic                    flush;
    logic                    last_q;
    act_buf_pkg::act_word_u  word_nxt;

    // Word is complete when its top lane fills or the frame ends.
    assign flush = pixel_valid && (pixel_last || lane_idx == LAST_LANE);

    // A flushed word is cleared so a short last word reads as zero padded.
    always_comb begin
        word_nxt = write_en ? '0 : data_in;
        if (pixel_valid) begin
            word_nxt.lanes[lane_idx] = pixel;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_in  <= '0;
            lane_idx <= '0;
            write_en <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            data_in  <= word_nxt;
            write_en <= flush;
            last_q   <= pixel_valid && pixel_last;
            if (pixel_valid) begin
                lane_idx <= flush ? '0 : lane_idx + 1'b1;
            end
        end
    end

    // The write address doubles as the word count of the frame.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_w      <= '0;
            frame_done  <= 1'b0;
            frame_words <= '0;
        end else begin
            frame_done <= write_en && last_q;
            if (write_en) begin
                if (last_q) begin
                    frame_words <= {1'b0, addr_w} + 1'b1;
                    addr_w      <= '0; // Next frame starts at word 0.
                end else begin
                    addr_w <= addr_w + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/act_buf_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module act_buf_ram #(
    parameter int words = `ACT_SRAM_WORDS,
    parameter int width = `ACT_LANES * `ACT_LANE_BITS
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [$clog2(words)-1:0] addr_r,
    input  logic [$clog2(words)-1:0] addr_w,
    input  logic                     read_en,
    input  logic                     write_en,
    input  logic [width-1:0]         data_in,
    output logic [width-1:0]         data_out
);

    logic [$clog2(words)-1:0] addr;
    logic                     web;
    logic                     csb;
    logic [width-1:0]         macro_do;
    logic                     read_en_d;
    logic [width-1:0]         do_hold;

    assign addr = write_en ? addr_w : addr_r; // Write wins a collision.
    assign web  = ~write_en;
    assign csb  = ~write_en & ~read_en;

    sram_macro_model #(
        .words   (words),
        .width   (width)
    ) u_macro (
        .clk     (clk),
        .a       (addr),
        .di      (data_in),
        .web     (web),
        .csb     (csb),
        .do_data (macro_do)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_en_d <= 1'b0;
        end else begin
            read_en_d <= read_en;
        end
    end

    // Keep the last read word once the macro output is no longer fresh.
    always_ff @(posedge clk) begin
        if (read_en_d) begin
            do_hold <= macro_do;
        end
    end

    assign data_out = read_en_d ? macro_do : do_hold;

endmodule

`default_nettype wire

//--- rtl/sram_macro_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "act_buf_macros.svh"

module sram_macro_model #(
    parameter int words = `ACT_SRAM_WORDS,
    parameter int width = `ACT_LANES * `ACT_LANE_BITS
) (
    input  logic                     clk,
    input  logic [$clog2(words)-1:0] a,
    input  logic [width-1:0]         di,
    input  logic                     web,
    input  logic                     csb,
    output logic [width-1:0]         do_data
);

    logic [width-1:0] mem [words];

    // Write cycles leave the output untouched, like the real macro.
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[a] <= di;
            end else begin
                do_data <= mem[a];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/act_buf_pkg.sv
`default_nettype none

`include "act_buf_macros.svh"

package act_buf_pkg;

    // One unsigned pixel lane.
    typedef logic [`ACT_LANE_BITS-1:0] lane_t;

    // An SRAM word seen either as one flat vector or as its lanes.
    // Lane 0 sits in the low bits and holds the first pixel of the word.
    typedef union packed {
        logic [`ACT_LANES*`ACT_LANE_BITS-1:0] flat;
        lane_t [`ACT_LANES-1:0]               lanes;
    } act_word_u;

endpackage

`default_nettype wire

//--- rtl/act_buf_macros.svh
`ifndef ACT_BUF_MACROS_SVH
`define ACT_BUF_MACROS_SVH

// Depth of the activation SRAM in words.
`define ACT_SRAM_WORDS 64

// Width of one pixel, which is also the width of one lane.
`define ACT_LANE_BITS 8

// Pixels packed into one SRAM word.
`define ACT_LANES 16

`endif
